/* cpu_alu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module cpu_alu import datapath_pkg::*; (
    input  word_t   alu_a,
    input  word_t   alu_b,
    input  alu_op_t alu_op,
    output word_t   alu_result
);

    // alu_a is the old top of stack, alu_b the entry below it
    always_comb begin
        case (alu_op)
            ALU_ADD: begin
                alu_result = alu_a + alu_b;
            end
            ALU_SUB: begin
                alu_result = alu_a - alu_b;
            end
            ALU_AND: begin
                alu_result = alu_a & alu_b;
            end
            ALU_OR: begin
                alu_result = alu_a | alu_b;
            end
            ALU_XOR: begin
                alu_result = alu_a ^ alu_b;
            end
            ALU_NOT: begin
                alu_result = ~alu_a;
            end
            default: begin
                alu_result = alu_a;
            end
        endcase
    end

endmodule

`default_nettype wire

/* cpu_consts.svh */
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// Datapath widths
`define CPU_WORD_W      16
`define CPU_OPCODE_W    5
`define CPU_PC_W        5
`define CPU_DADDR_W     10

`define CPU_STACK_DEPTH 32

// Opcode encodings
`define CPU_OP_PUSH     5'd0
`define CPU_OP_PUSH_I   5'd1
`define CPU_OP_POP      5'd3
`define CPU_OP_ADD      5'd4
`define CPU_OP_SUB      5'd5
`define CPU_OP_AND      5'd8
`define CPU_OP_OR       5'd10
`define CPU_OP_XOR      5'd11
`define CPU_OP_NOT      5'd13
`define CPU_OP_GOTO     5'd14
`define CPU_OP_IF_EQ    5'd15
`define CPU_OP_IF_GT    5'd16
`define CPU_OP_CALL     5'd20
`define CPU_OP_RET      5'd21

`endif

/* cpu_control.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module cpu_control import isa_pkg::*, datapath_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    output pc_t     imem_addr,
    output logic    imem_read,
    input  word_t   instruction,
    output daddr_t  dmem_addr,
    output logic    dmem_read,
    input  word_t   dmem_rdata,
    output logic    dmem_write,
    output word_t   dmem_wdata,
    output logic    op_push,
    output logic    op_pop,
    output word_t   op_data_in,
    input  word_t   op_data_out,
    input  logic    op_empty,
    output logic    ret_push,
    output logic    ret_pop,
    output pc_t     ret_data_in,
    input  pc_t     ret_data_out,
    input  logic    ret_empty,
    output word_t   alu_a,
    output word_t   alu_b,
    output alu_op_t alu_op,
    input  word_t   alu_result
);

    typedef enum logic [3:0] {
        S_IDLE,
        S_FETCH,
        S_DECODE,
        S_RD_REQ,
        S_RD_PUSH,
        S_PUSH_IMM,
        S_POP_WR,
        S_WRITE,
        S_POP_A,
        S_POP_B,
        S_EXEC,
        S_POP_COND,
        S_BRANCH,
        S_CALL,
        S_RET,
        S_NEXT
    } state_t;

    state_t state;
    state_t state_next;
    pc_t    pc;
    pc_t    pc_next;
    pc_t    pc_inc;
    pc_t    target;
    instr_t instr_in;
    instr_t ir;
    word_t  hold_a;
    word_t  hold_b;
    logic   taken;
    logic   consumes_op;

    assign instr_in    = instruction;
    assign pc_inc      = pc + 1'b1;
    assign target      = ir.addr_view.daddr[`CPU_PC_W-1:0];
    assign imem_addr   = pc;
    assign dmem_addr   = ir.addr_view.daddr;
    assign dmem_wdata  = hold_a;
    assign ret_data_in = pc_inc;
    assign alu_a       = hold_a;
    assign alu_b       = hold_b;

    assign consumes_op = instr_in.addr_view.opcode inside {
        OP_POP, OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_NOT, OP_IF_EQ, OP_IF_GT
    };

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= S_IDLE;
            pc    <= '0;
        end else begin
            state <= state_next;
            pc    <= pc_next;
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_DECODE) begin
            ir <= instr_in;
        end
        // Capture the top entry in the same cycle it is popped
        if (state inside {S_POP_WR, S_POP_A, S_POP_COND}) begin
            hold_a <= op_data_out;
        end
        if (state == S_POP_B) begin
            hold_b <= op_data_out;
        end
    end

    always_comb begin
        case (ir.addr_view.opcode)
            OP_SUB:  alu_op = ALU_SUB;
            OP_AND:  alu_op = ALU_AND;
            OP_OR:   alu_op = ALU_OR;
            OP_XOR:  alu_op = ALU_XOR;
            OP_NOT:  alu_op = ALU_NOT;
            default: alu_op = ALU_ADD;
        endcase
    end

    // GOTO shares the branch state and is always taken
    always_comb begin
        case (ir.addr_view.opcode)
            OP_GOTO:  taken = 1'b1;
            OP_IF_EQ: taken = (hold_a == '0);
            OP_IF_GT: taken = ($signed(hold_a) > 0);
            default:  taken = 1'b0;
        endcase
    end

    always_comb begin
        state_next = state;
        pc_next    = pc;
        imem_read  = 1'b0;
        dmem_read  = 1'b0;
        dmem_write = 1'b0;
        op_push    = 1'b0;
        op_pop     = 1'b0;
        op_data_in = alu_result;
        ret_push   = 1'b0;
        ret_pop    = 1'b0;
        case (state)
            S_IDLE: begin
                state_next = S_FETCH;
            end
            S_FETCH: begin
                imem_read  = 1'b1;
                state_next = S_DECODE;
            end
            S_DECODE: begin
                case (instr_in.addr_view.opcode)
                    OP_PUSH:   state_next = S_RD_REQ;
                    OP_PUSH_I: state_next = S_PUSH_IMM;
                    OP_POP:    state_next = S_POP_WR;
                    OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_NOT: begin
                        state_next = S_POP_A;
                    end
                    OP_GOTO:   state_next = S_BRANCH;
                    OP_IF_EQ, OP_IF_GT: begin
                        state_next = S_POP_COND;
                    end
                    OP_CALL:   state_next = S_CALL;
                    OP_RET:    state_next = S_RET;
                    default:   state_next = S_NEXT;
                endcase
            end
            S_RD_REQ: begin
                dmem_read  = 1'b1;
                state_next = S_RD_PUSH;
            end
            S_RD_PUSH: begin
                op_push    = 1'b1;
                op_data_in = dmem_rdata;
                pc_next    = pc_inc;
                state_next = S_FETCH;
            end
            S_PUSH_IMM: begin
                op_push    = 1'b1;
                op_data_in = word_t'(ir.imm_view.imm);
                pc_next    = pc_inc;
                state_next = S_FETCH;
            end
            S_POP_WR: begin
                op_pop     = 1'b1;
                state_next = S_WRITE;
            end
            S_WRITE: begin
                dmem_write = 1'b1;
                pc_next    = pc_inc;
                state_next = S_FETCH;
            end
            S_POP_A: begin
                op_pop     = 1'b1;
                state_next = S_POP_B;
            end
            S_POP_B: begin
                op_pop     = 1'b1;
                state_next = S_EXEC;
            end
            S_EXEC: begin
                op_push    = 1'b1;
                pc_next    = pc_inc;
                state_next = S_FETCH;
            end
            S_POP_COND: begin
                op_pop     = 1'b1;
                state_next = S_BRANCH;
            end
            S_BRANCH: begin
                pc_next    = taken ? target : pc_inc;
                state_next = S_FETCH;
            end
            S_CALL: begin
                ret_push   = 1'b1;
                pc_next    = target;
                state_next = S_FETCH;
            end
            S_RET: begin
                ret_pop    = 1'b1;
                pc_next    = ret_data_out;
                state_next = S_FETCH;
            end
            default: begin
                pc_next    = pc_inc;
                state_next = S_FETCH;
            end
        endcase
    end

    a_fetch_not_write: assert property (@(posedge clk) disable iff (reset)
        !(imem_read && dmem_write));

    a_read_not_write: assert property (@(posedge clk) disable iff (reset)
        !(dmem_read && dmem_write));

    // Program error caught at decode, before any stack strobe
    a_operands_present: assert property (@(posedge clk) disable iff (reset)
        state == S_DECODE |-> !(consumes_op && op_empty) &&
            !(instr_in.addr_view.opcode == OP_RET && ret_empty));

endmodule

`default_nettype wire

/* cpu_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module cpu_top import datapath_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    output pc_t    imem_addr,
    output logic   imem_read,
    input  word_t  instruction,
    output daddr_t dmem_addr,
    output logic   dmem_read,
    input  word_t  dmem_rdata,
    output logic   dmem_write,
    output word_t  dmem_wdata
);

    logic    op_push;
    logic    op_pop;
    word_t   op_data_in;
    word_t   op_data_out;
    logic    op_empty;
    logic    ret_push;
    logic    ret_pop;
    pc_t     ret_data_in;
    pc_t     ret_data_out;
    logic    ret_empty;
    word_t   alu_a;
    word_t   alu_b;
    alu_op_t alu_op;
    word_t   alu_result;

    cpu_control u_control (
        .clk          (clk),
        .reset        (reset),
        .imem_addr    (imem_addr),
        .imem_read    (imem_read),
        .instruction  (instruction),
        .dmem_addr    (dmem_addr),
        .dmem_read    (dmem_read),
        .dmem_rdata   (dmem_rdata),
        .dmem_write   (dmem_write),
        .dmem_wdata   (dmem_wdata),
        .op_push      (op_push),
        .op_pop       (op_pop),
        .op_data_in   (op_data_in),
        .op_data_out  (op_data_out),
        .op_empty     (op_empty),
        .ret_push     (ret_push),
        .ret_pop      (ret_pop),
        .ret_data_in  (ret_data_in),
        .ret_data_out (ret_data_out),
        .ret_empty    (ret_empty),
        .alu_a        (alu_a),
        .alu_b        (alu_b),
        .alu_op       (alu_op),
        .alu_result   (alu_result)
    );

    cpu_alu u_alu (
        .alu_a      (alu_a),
        .alu_b      (alu_b),
        .alu_op     (alu_op),
        .alu_result (alu_result)
    );

    // Expression stack
    stack_lifo #(
        .WIDTH ($bits(word_t)),
        .DEPTH (`CPU_STACK_DEPTH)
    ) operand_stack (
        .clk      (clk),
        .reset    (reset),
        .push     (op_push),
        .pop      (op_pop),
        .data_in  (op_data_in),
        .data_out (op_data_out),
        .full     (),
        .empty    (op_empty)
    );

    // Return addresses for CALL and RET
    stack_lifo #(
        .WIDTH ($bits(pc_t)),
        .DEPTH (`CPU_STACK_DEPTH)
    ) return_stack (
        .clk      (clk),
        .reset    (reset),
        .push     (ret_push),
        .pop      (ret_pop),
        .data_in  (ret_data_in),
        .data_out (ret_data_out),
        .full     (),
        .empty    (ret_empty)
    );

endmodule

`default_nettype wire

/* datapath_pkg.sv */
`default_nettype none

`include "cpu_consts.svh"

package datapath_pkg;

    typedef logic [`CPU_WORD_W-1:0]  word_t;
    typedef logic [`CPU_PC_W-1:0]    pc_t;
    typedef logic [`CPU_DADDR_W-1:0] daddr_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOT
    } alu_op_t;

endpackage

`default_nettype wire

/* flist.f */
+incdir+.
isa_pkg.sv
datapath_pkg.sv
stack_lifo.sv
cpu_alu.sv
cpu_control.sv
cpu_top.sv
tb_cpu.sv

/* isa_pkg.sv */
`default_nettype none

`include "cpu_consts.svh"

package isa_pkg;

    typedef enum logic [`CPU_OPCODE_W-1:0] {
        OP_PUSH   = `CPU_OP_PUSH,
        OP_PUSH_I = `CPU_OP_PUSH_I,
        OP_POP    = `CPU_OP_POP,
        OP_ADD    = `CPU_OP_ADD,
        OP_SUB    = `CPU_OP_SUB,
        OP_AND    = `CPU_OP_AND,
        OP_OR     = `CPU_OP_OR,
        OP_XOR    = `CPU_OP_XOR,
        OP_NOT    = `CPU_OP_NOT,
        OP_GOTO   = `CPU_OP_GOTO,
        OP_IF_EQ  = `CPU_OP_IF_EQ,
        OP_IF_GT  = `CPU_OP_IF_GT,
        OP_CALL   = `CPU_OP_CALL,
        OP_RET    = `CPU_OP_RET
    } opcode_t;

    // Immediate view, used by PUSH_I
    typedef struct packed {
        opcode_t                                 opcode;
        logic [`CPU_WORD_W-`CPU_OPCODE_W-1:0]    imm;
    } instr_imm_t;

    // Address view, low bits of daddr double as jump target
    typedef struct packed {
        opcode_t                                             opcode;
        logic [`CPU_WORD_W-`CPU_OPCODE_W-`CPU_DADDR_W-1:0]   pad;
        logic [`CPU_DADDR_W-1:0]                             daddr;
    } instr_addr_t;

    typedef union packed {
        instr_imm_t  imm_view;
        instr_addr_t addr_view;
    } instr_t;

endpackage

`default_nettype wire

/* stack_lifo.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module stack_lifo #(
    parameter int WIDTH = `CPU_WORD_W,
    parameter int DEPTH = `CPU_STACK_DEPTH
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             push,
    input  logic             pop,
    input  logic [WIDTH-1:0] data_in,
    output logic [WIDTH-1:0] data_out,
    output logic             full,
    output logic             empty
);

    localparam int ADDR_W = $clog2(DEPTH);
    localparam int CNT_W  = $clog2(DEPTH + 1);

    logic [WIDTH-1:0]  mem [DEPTH];
    logic [CNT_W-1:0]  count;
    logic [ADDR_W-1:0] top_idx;
    logic [ADDR_W-1:0] wr_idx;

    assign top_idx  = ADDR_W'(count - 1'b1);
    assign wr_idx   = ADDR_W'(count);
    assign data_out = mem[top_idx];
    assign full     = (count == CNT_W'(DEPTH));
    assign empty    = (count == '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (push && !pop) begin
            count <= count + 1'b1;
        end else if (pop && !push) begin
            count <= count - 1'b1;
        end
    end

    // Push with pop in one cycle replaces the top entry
    always_ff @(posedge clk) begin
        if (push && pop) begin
            mem[top_idx] <= data_in;
        end else if (push) begin
            mem[wr_idx] <= data_in;
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (reset)
        !(push && !pop && full));

    a_no_underflow: assert property (@(posedge clk) disable iff (reset)
        !(pop && empty));

endmodule

`default_nettype wire

/* tb_cpu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module tb_cpu import isa_pkg::*; ();

    localparam int WORD_W    = `CPU_WORD_W;
    localparam int PC_W      = `CPU_PC_W;
    localparam int DADDR_W   = `CPU_DADDR_W;
    localparam int ROM_SIZE  = 1 << `CPU_PC_W;
    localparam int RAM_SIZE  = 1 << `CPU_DADDR_W;
    localparam int RUN_LIMIT = 4000;

    logic               clk = 1'b0;
    logic               reset;
    logic [PC_W-1:0]    imem_addr;
    logic               imem_read;
    logic [WORD_W-1:0]  instruction;
    logic [DADDR_W-1:0] dmem_addr;
    logic               dmem_read;
    logic [WORD_W-1:0]  dmem_rdata;
    logic               dmem_write;
    logic [WORD_W-1:0]  dmem_wdata;

    logic [WORD_W-1:0]  rom     [ROM_SIZE];
    logic [WORD_W-1:0]  ram     [RAM_SIZE];
    logic [WORD_W-1:0]  ref_ram [RAM_SIZE];
    logic [31:0]        lfsr_state;

    logic [PC_W-1:0]    exp_fetch [$];
    logic [DADDR_W-1:0] exp_raddr [$];
    logic [DADDR_W-1:0] exp_waddr [$];
    logic [WORD_W-1:0]  exp_wdata [$];
    int                 fetch_idx;
    int                 read_idx;
    int                 write_idx;
    logic               first_cycle;

    // Bus requests seen in the previous cycle
    logic               i_req;
    logic [PC_W-1:0]    i_addr;
    logic               d_req;
    logic               d_wr;
    logic [DADDR_W-1:0] d_addr;
    logic [WORD_W-1:0]  d_wdata;

    cpu_top DUT (
        .clk         (clk),
        .reset       (reset),
        .imem_addr   (imem_addr),
        .imem_read   (imem_read),
        .instruction (instruction),
        .dmem_addr   (dmem_addr),
        .dmem_read   (dmem_read),
        .dmem_rdata  (dmem_rdata),
        .dmem_write  (dmem_write),
        .dmem_wdata  (dmem_wdata)
    );

    always #4 clk = ~clk;

    task automatic stop_with_failure();
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("error: time %0t signal %s got %h expected %h",
                     $time, name, got, expected);
            stop_with_failure();
        end
    endtask

    // Galois form, polynomial x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [WORD_W-1:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[WORD_W-2:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    function automatic logic [WORD_W-1:0] enc_imm(input opcode_t op, input logic [10:0] imm);
        instr_t w;
        w = '0;
        w.imm_view.opcode = op;
        w.imm_view.imm    = imm;
        return w;
    endfunction

    function automatic logic [WORD_W-1:0] enc_addr(input opcode_t op,
                                                   input logic [DADDR_W-1:0] addr);
        instr_t w;
        w = '0;
        w.addr_view.opcode = op;
        w.addr_view.daddr  = addr;
        return w;
    endfunction

    task automatic load_program();
        logic [WORD_W-1:0] v;
        logic [10:0]       imm0;
        logic [10:0]       imm1;
        logic [10:0]       imm2;
        int                a;
        for (a = 0; a < RAM_SIZE; a++) begin
            take_bits(16, v);
            ram[a] = v;
        end
        // SUB wraps, branch operands negative and positive
        ram[100] = ram[100] | 16'h8000;
        ram[101] = ram[101] & 16'h7fff;
        ram[110] = ram[110] | 16'h8000;
        ram[112] = (ram[112] & 16'h7fff) | 16'h0001;
        take_bits(11, v);
        imm0 = v[10:0] | 11'h400;
        take_bits(11, v);
        imm1 = v[10:0];
        take_bits(11, v);
        imm2 = v[10:0];

        rom[0]  = enc_imm(OP_PUSH_I, imm0);
        rom[1]  = enc_addr(OP_POP, 10'd200);
        rom[2]  = enc_addr(OP_PUSH, 10'd100);
        rom[3]  = enc_addr(OP_PUSH, 10'd101);
        rom[4]  = enc_addr(OP_SUB, 10'd0);
        rom[5]  = enc_addr(OP_PUSH, 10'd102);
        rom[6]  = enc_addr(OP_ADD, 10'd0);
        rom[7]  = enc_addr(OP_PUSH, 10'd103);
        rom[8]  = enc_addr(OP_AND, 10'd0);
        rom[9]  = enc_addr(OP_PUSH, 10'd104);
        rom[10] = enc_addr(OP_OR, 10'd0);
        rom[11] = enc_imm(OP_PUSH_I, imm1);
        rom[12] = enc_imm(OP_PUSH_I, imm2);
        rom[13] = enc_addr(OP_NOT, 10'd0);
        rom[14] = enc_addr(OP_XOR, 10'd0);
        rom[15] = enc_addr(OP_POP, 10'd201);
        // Branches not taken
        rom[16] = enc_addr(OP_PUSH, 10'd110);
        rom[17] = enc_addr(OP_IF_GT, 10'd31);
        rom[18] = enc_imm(OP_PUSH_I, 11'd0);
        rom[19] = enc_addr(OP_IF_GT, 10'd31);
        rom[20] = enc_addr(OP_PUSH, 10'd112);
        rom[21] = enc_addr(OP_IF_EQ, 10'd31);
        // Branches taken, each skips one GOTO
        rom[22] = enc_imm(OP_PUSH_I, 11'd0);
        rom[23] = enc_addr(OP_IF_EQ, 10'd25);
        rom[24] = enc_addr(OP_GOTO, 10'd31);
        rom[25] = enc_addr(OP_PUSH, 10'd112);
        rom[26] = enc_addr(OP_IF_GT, 10'd28);
        rom[27] = enc_addr(OP_GOTO, 10'd31);
        rom[28] = enc_addr(OP_CALL, 10'd30);
        rom[29] = enc_addr(OP_GOTO, 10'd31);
        rom[30] = enc_addr(OP_RET, 10'd0);
        rom[31] = enc_addr(OP_GOTO, 10'd31);
    endtask

    // Interprets the program by the ISA rules, stops after three self-loop fetches
    function automatic void run_reference();
        logic [WORD_W-1:0]  stk  [32];
        logic [PC_W-1:0]    rstk [32];
        int                 sp;
        int                 rsp;
        int                 steps;
        int                 loop_hits;
        logic [PC_W-1:0]    pc;
        logic [PC_W-1:0]    pc_next;
        logic [PC_W-1:0]    target;
        logic [DADDR_W-1:0] addr;
        instr_t             ir;
        logic [WORD_W-1:0]  a;
        logic [WORD_W-1:0]  b;
        sp        = 0;
        rsp       = 0;
        steps     = 0;
        loop_hits = 0;
        pc        = '0;
        while (loop_hits < 3 && steps < 200) begin
            exp_fetch.push_back(pc);
            ir      = rom[pc];
            addr    = ir.addr_view.daddr;
            target  = addr[PC_W-1:0];
            pc_next = pc + 1'b1;
            case (ir.addr_view.opcode)
                OP_PUSH: begin
                    stk[sp] = ref_ram[addr];
                    sp++;
                    exp_raddr.push_back(addr);
                end
                OP_PUSH_I: begin
                    stk[sp] = {{(WORD_W-11){1'b0}}, ir.imm_view.imm};
                    sp++;
                end
                OP_POP: begin
                    sp--;
                    ref_ram[addr] = stk[sp];
                    exp_waddr.push_back(addr);
                    exp_wdata.push_back(stk[sp]);
                end
                OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_NOT: begin
                    a  = stk[sp-1];
                    b  = stk[sp-2];
                    sp = sp - 1;
                    case (ir.addr_view.opcode)
                        OP_ADD:  stk[sp-1] = a + b;
                        OP_SUB:  stk[sp-1] = a - b;
                        OP_AND:  stk[sp-1] = a & b;
                        OP_OR:   stk[sp-1] = a | b;
                        OP_XOR:  stk[sp-1] = a ^ b;
                        default: stk[sp-1] = ~a;
                    endcase
                end
                OP_GOTO: begin
                    if (target == pc) begin
                        loop_hits++;
                    end
                    pc_next = target;
                end
                OP_IF_EQ: begin
                    sp--;
                    if (stk[sp] == '0) begin
                        pc_next = target;
                    end
                end
                OP_IF_GT: begin
                    sp--;
                    if ($signed(stk[sp]) > 0) begin
                        pc_next = target;
                    end
                end
                OP_CALL: begin
                    rstk[rsp] = pc + 1'b1;
                    rsp++;
                    pc_next = target;
                end
                OP_RET: begin
                    rsp--;
                    pc_next = rstk[rsp];
                end
                default: begin
                end
            endcase
            pc = pc_next;
            steps++;
        end
    endfunction

    // One-cycle read memories, requests taken at the falling edge
    always begin
        @(negedge clk);
        i_req   = imem_read;
        i_addr  = imem_addr;
        d_req   = dmem_read;
        d_wr    = dmem_write;
        d_addr  = dmem_addr;
        d_wdata = dmem_wdata;
        @(posedge clk);
        #1;
        if (i_req === 1'b1) begin
            instruction = rom[i_addr];
        end
        if (d_req === 1'b1) begin
            dmem_rdata = ram[d_addr];
        end
        if (d_wr === 1'b1) begin
            ram[d_addr] = d_wdata;
        end
    end

    always @(negedge clk) begin
        if (reset || first_cycle) begin
            check_value("imem_read", imem_read, 0);
            check_value("dmem_read", dmem_read, 0);
            check_value("dmem_write", dmem_write, 0);
            if (!reset) begin
                first_cycle = 1'b0;
            end
        end else begin
            if (imem_read && fetch_idx < exp_fetch.size()) begin
                check_value("imem_addr", imem_addr, exp_fetch[fetch_idx]);
                fetch_idx++;
            end
            if (dmem_read) begin
                if (read_idx >= exp_raddr.size()) begin
                    $display("data read at time %0t was not expected", $time);
                    stop_with_failure();
                end
                check_value("dmem_addr", dmem_addr, exp_raddr[read_idx]);
                read_idx++;
            end
            if (dmem_write) begin
                if (write_idx >= exp_waddr.size()) begin
                    $display("data write at time %0t was not expected", $time);
                    stop_with_failure();
                end
                check_value("dmem_addr", dmem_addr, exp_waddr[write_idx]);
                check_value("dmem_wdata", dmem_wdata, exp_wdata[write_idx]);
                write_idx++;
            end
        end
    end

    initial begin
        int cycles;
        int a;
        reset       = 1'b1;
        instruction = '0;
        dmem_rdata  = '0;
        fetch_idx   = 0;
        read_idx    = 0;
        write_idx   = 0;
        first_cycle = 1'b1;
        lfsr_state  = 32'hc6da_1d1c;
        load_program();
        for (a = 0; a < RAM_SIZE; a++) begin
            ref_ram[a] = ram[a];
        end
        run_reference();

        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;

        cycles = 0;
        while (fetch_idx < exp_fetch.size() && cycles < RUN_LIMIT) begin
            @(posedge clk);
            cycles++;
        end

        if (fetch_idx < exp_fetch.size()) begin
            $display("timeout: only %0d of %0d expected fetches seen",
                     fetch_idx, exp_fetch.size());
            stop_with_failure();
        end else if (write_idx != exp_waddr.size() || read_idx != exp_raddr.size()) begin
            $display("program ended with %0d of %0d data writes and %0d of %0d data reads",
                     write_idx, exp_waddr.size(), read_idx, exp_raddr.size());
            stop_with_failure();
        end else begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule

`default_nettype wire
